// ==== include/axil_sram_cfg.svh ====
`ifndef AXIL_SRAM_CFG_SVH
`define AXIL_SRAM_CFG_SVH

// bus side
`define AXIL_ADDR_WIDTH 16
`define AXIL_DATA_WIDTH 16
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// memory side, word addressed
`define SRAM_ADDR_LSB ($clog2(`AXIL_STRB_WIDTH))
`define SRAM_ADDR_WIDTH (`AXIL_ADDR_WIDTH - `SRAM_ADDR_LSB)
`define SRAM_DEPTH 1024

`endif

// ==== src/axil_pkg.sv ====
`include "axil_sram_cfg.svh"

package axil_pkg;

  // only the two codes this slave ever returns
  typedef enum logic [1:0] {
    axil_okay   = 2'b00,
    axil_slverr = 2'b10
  } axil_resp_e;

  // write address
  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] awaddr;
  } axil_aw_t;

  // write data
  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0] wdata;
    logic [`AXIL_STRB_WIDTH-1:0] wstrb;
  } axil_w_t;

  // write response
  typedef struct packed {
    axil_resp_e bresp;
  } axil_b_t;

  // read address
  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] araddr;
  } axil_ar_t;

  // read data
  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0] rdata;
    axil_resp_e                  rresp;
  } axil_r_t;

endpackage

// ==== src/sram_pkg.sv ====
`include "axil_sram_cfg.svh"

package sram_pkg;

  typedef enum logic {
    sram_rd = 1'b0,
    sram_wr = 1'b1
  } sram_op_e;

  // one command per bus transaction
  typedef struct packed {
    sram_op_e                    op;
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`AXIL_DATA_WIDTH-1:0] wdata;
    logic [`AXIL_STRB_WIDTH-1:0] wstrb;
  } sram_cmd_t;

  // read return only, writes have no response
  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0] rdata;
  } sram_resp_t;

endpackage

// ==== src/sram_array.sv ====
`include "axil_sram_cfg.svh"

module sram_array (
  input  logic                 clk,
  input  logic                 rst_n,

  input  sram_pkg::sram_cmd_t  cmd,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,

  output sram_pkg::sram_resp_t resp,
  output logic                 resp_valid,
  input  logic                 resp_ready
);

  localparam int idx_w = $clog2(`SRAM_DEPTH);

  logic [`AXIL_DATA_WIDTH-1:0] mem [`SRAM_DEPTH];
  logic [idx_w-1:0]            mem_idx;
  logic                        cmd_hs;
  sram_pkg::sram_resp_t        resp_q;
  logic                        resp_valid_q;

  assign mem_idx = cmd.addr[idx_w-1:0];
  assign cmd_hs  = cmd_valid && cmd_ready;

  // stall only while a read result is still unclaimed
  assign cmd_ready = !resp_valid_q;

  // byte lane writes
  always_ff @(posedge clk) begin
    if (cmd_hs && (cmd.op == sram_pkg::sram_wr)) begin
      for (int i = 0; i < `AXIL_STRB_WIDTH; i++) begin
        if (cmd.wstrb[i]) begin
          mem[mem_idx][i*8 +: 8] <= cmd.wdata[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_hs && (cmd.op == sram_pkg::sram_rd)) begin
      resp_q.rdata <= mem[mem_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid_q <= 1'b0;
    end else if (cmd_hs && (cmd.op == sram_pkg::sram_rd)) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp       = resp_q;
  assign resp_valid = resp_valid_q;

  // range is the bridge's job, array trusts it
  assert property (@(posedge clk) disable iff (!rst_n)
    cmd_hs |-> (32'(cmd.addr) < 32'(`SRAM_DEPTH)))
    else $error("sram command address 0x%0h past depth", cmd.addr);

endmodule

// ==== src/axil_sram_bridge.sv ====
`include "axil_sram_cfg.svh"

module axil_sram_bridge (
  input  logic                 clk,
  input  logic                 rst_n,

  input  axil_pkg::axil_aw_t   aw,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  axil_pkg::axil_w_t    w,
  input  logic                 w_valid,
  output logic                 w_ready,
  output axil_pkg::axil_b_t    b,
  output logic                 b_valid,
  input  logic                 b_ready,

  input  axil_pkg::axil_ar_t   ar,
  input  logic                 ar_valid,
  output logic                 ar_ready,
  output axil_pkg::axil_r_t    r,
  output logic                 r_valid,
  input  logic                 r_ready,

  output sram_pkg::sram_cmd_t  cmd,
  output logic                 cmd_valid,
  input  logic                 cmd_ready,
  input  sram_pkg::sram_resp_t resp,
  input  logic                 resp_valid,
  output logic                 resp_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_cmd,
    st_wait_rd,
    st_resp
  } state_e;

  state_e                      state;
  logic                        last_wr;
  logic                        take_wr;
  logic                        take_rd;
  logic                        addr_hs;
  logic [`AXIL_ADDR_WIDTH-1:0] sel_addr;
  logic [`SRAM_ADDR_WIDTH-1:0] word_addr;
  logic                        in_range;

  sram_pkg::sram_cmd_t         cmd_q;
  logic                        cmd_valid_q;
  axil_pkg::axil_b_t           b_q;
  logic                        b_valid_q;
  axil_pkg::axil_r_t           r_q;
  logic                        r_valid_q;

  // write needs both aw and w; on a tie serve the side not taken last
  assign take_wr = aw_valid && w_valid && (!ar_valid || !last_wr);
  assign take_rd = ar_valid && !take_wr;

  assign aw_ready = (state == st_idle) && take_wr;
  assign w_ready  = aw_ready;
  assign ar_ready = (state == st_idle) && take_rd;
  assign addr_hs  = aw_ready || ar_ready;

  assign sel_addr  = take_wr ? aw.awaddr : ar.araddr;
  assign word_addr = sel_addr[`AXIL_ADDR_WIDTH-1:`SRAM_ADDR_LSB];
  assign in_range  = 32'(word_addr) < 32'(`SRAM_DEPTH);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      last_wr     <= 1'b0;
      cmd_valid_q <= 1'b0;
      b_valid_q   <= 1'b0;
      r_valid_q   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (addr_hs) begin
            last_wr <= take_wr;
            if (in_range) begin
              cmd_valid_q <= 1'b1;
              state       <= st_cmd;
            end else begin
              // out of range, answer straight away
              b_valid_q <= take_wr;
              r_valid_q <= take_rd;
              state     <= st_resp;
            end
          end
        end
        st_cmd: begin
          if (cmd_ready) begin
            cmd_valid_q <= 1'b0;
            if (cmd_q.op == sram_pkg::sram_wr) begin
              b_valid_q <= 1'b1;
              state     <= st_resp;
            end else begin
              state <= st_wait_rd;
            end
          end
        end
        st_wait_rd: begin
          if (resp_valid) begin
            r_valid_q <= 1'b1;
            state     <= st_resp;
          end
        end
        st_resp: begin
          if ((b_valid_q && b_ready) || (r_valid_q && r_ready)) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (addr_hs) begin
      cmd_q.op    <= take_wr ? sram_pkg::sram_wr : sram_pkg::sram_rd;
      cmd_q.addr  <= word_addr;
      cmd_q.wdata <= take_wr ? w.wdata : '0;
      cmd_q.wstrb <= take_wr ? w.wstrb : '0;
      b_q.bresp   <= in_range ? axil_pkg::axil_okay : axil_pkg::axil_slverr;
      r_q.rresp   <= in_range ? axil_pkg::axil_okay : axil_pkg::axil_slverr;
      r_q.rdata   <= '0;
    end
    if ((state == st_wait_rd) && resp_valid) begin
      r_q.rdata <= resp.rdata;
    end
  end

  assign cmd        = cmd_q;
  assign cmd_valid  = cmd_valid_q;
  assign resp_ready = (state == st_wait_rd);
  assign b          = b_q;
  assign b_valid    = b_valid_q;
  assign r          = r_q;
  assign r_valid    = r_valid_q;

  // responses hold until taken
  assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b_valid dropped or b changed before b_ready");

  assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("r_valid dropped or r changed before r_ready");

  assert property (@(posedge clk) disable iff (!rst_n)
    (state == st_idle) |-> !cmd_valid)
    else $error("cmd_valid high while idle");

  assert property (@(posedge clk) disable iff (!rst_n)
    !(b_valid && r_valid))
    else $error("b_valid and r_valid both high");

endmodule

// ==== src/axil_sram_top.sv ====
module axil_sram_top (
  input  logic               clk,
  input  logic               rst_n,

  input  axil_pkg::axil_aw_t aw,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axil_pkg::axil_w_t  w,
  input  logic               w_valid,
  output logic               w_ready,
  output axil_pkg::axil_b_t  b,
  output logic               b_valid,
  input  logic               b_ready,

  input  axil_pkg::axil_ar_t ar,
  input  logic               ar_valid,
  output logic               ar_ready,
  output axil_pkg::axil_r_t  r,
  output logic               r_valid,
  input  logic               r_ready
);

  // inner command and read return links
  sram_pkg::sram_cmd_t  cmd;
  logic                 cmd_valid;
  logic                 cmd_ready;
  sram_pkg::sram_resp_t resp;
  logic                 resp_valid;
  logic                 resp_ready;

  axil_sram_bridge u_bridge (
    .clk        (clk),
    .rst_n      (rst_n),
    .aw         (aw),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w          (w),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b          (b),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .ar         (ar),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  sram_array u_sram (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

endmodule

// ==== testbench/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int half_period  = 20,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== testbench/axil_sram_tb.sv ====
`include "axil_sram_cfg.svh"

module axil_sram_tb;

  localparam int wait_limit = 50;

  logic               clk;
  logic               rst_n;
  axil_pkg::axil_aw_t aw;
  logic               aw_valid;
  logic               aw_ready;
  axil_pkg::axil_w_t  w;
  logic               w_valid;
  logic               w_ready;
  axil_pkg::axil_b_t  b;
  logic               b_valid;
  logic               b_ready;
  axil_pkg::axil_ar_t ar;
  logic               ar_valid;
  logic               ar_ready;
  axil_pkg::axil_r_t  r;
  logic               r_valid;
  logic               r_ready;

  int value_errs = 0;
  int other_errs = 0;
  int cyc = 0;
  bit hung = 1'b0;

  tb_clk_gen clk_gen (.clk(clk), .rst_n(rst_n));

  axil_sram_top dut (
    .clk   (clk),
    .rst_n (rst_n),
    .aw    (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
  );

  // cycle stamp for telling which request was granted first
  always @(negedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic finish_run();
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic report_hang(input string chan);
    $display("timeout: nothing happened on the %s for %0d cycles", chan, wait_limit);
    other_errs++;
    hung = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("FAIL %s expected 0x%0h got 0x%0h", name, exp, got);
        value_errs++;
      end
  endtask

  // byte lanes with a set strobe take the new data
  function automatic logic [`AXIL_DATA_WIDTH-1:0] merge_bytes(
    input logic [`AXIL_DATA_WIDTH-1:0] old_word,
    input logic [`AXIL_DATA_WIDTH-1:0] new_word,
    input logic [`AXIL_STRB_WIDTH-1:0] strb
  );
    logic [`AXIL_DATA_WIDTH-1:0] res;
    res = old_word;
    for (int k = 0; k < `AXIL_STRB_WIDTH; k++) begin
      if (strb[k]) begin
        res[k*8 +: 8] = new_word[k*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] resp_payload(input bit is_wr);
    logic [31:0] v;
    if (is_wr) begin
      v = 32'(b);
    end else begin
      v = 32'(r);
    end
    return v;
  endfunction

  task automatic send_addr(input bit is_wr, input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                           input logic [`AXIL_DATA_WIDTH-1:0] data,
                           input logic [`AXIL_STRB_WIDTH-1:0] strb, output int hs_cyc);
    int i;
    @(negedge clk);
    if (is_wr) begin
      aw.awaddr = addr;
      w.wdata   = data;
      w.wstrb   = strb;
      aw_valid  = 1'b1;
      w_valid   = 1'b1;
    end else begin
      ar.araddr = addr;
      ar_valid  = 1'b1;
    end
    for (i = 0; i < wait_limit; i++) begin
      @(posedge clk);
      if (is_wr ? (aw_ready && w_ready) : ar_ready) begin
        break;
      end
    end
    if (i == wait_limit) begin
      if (is_wr) begin
        report_hang("write address channel");
      end else begin
        report_hang("read address channel");
      end
    end
    hs_cyc = cyc;
    @(negedge clk);
    if (is_wr) begin
      aw_valid = 1'b0;
      w_valid  = 1'b0;
    end else begin
      ar_valid = 1'b0;
    end
  endtask

  task automatic take_resp(input bit is_wr, output logic [1:0] resp,
                           output logic [`AXIL_DATA_WIDTH-1:0] rdata);
    int i;
    int stall;
    logic [31:0] snap;
    resp  = 'x;
    rdata = 'x;
    for (i = 0; i < wait_limit; i++) begin
      @(negedge clk);
      if (is_wr ? b_valid : r_valid) begin
        break;
      end
    end
    if (i == wait_limit) begin
      if (is_wr) begin
        report_hang("write response channel");
      end else begin
        report_hang("read data channel");
      end
    end else begin
      snap  = resp_payload(is_wr);
      resp  = is_wr ? b.bresp : r.rresp;
      rdata = r.rdata;
      // a request queued behind this one sees at least one stalled cycle
      if (aw_valid || ar_valid) begin
        stall = 1 + $urandom % 3;
      end else begin
        stall = $urandom % 4;
      end
      repeat (stall) begin
        @(posedge clk);
        // queued request waits until the response is taken
        if (aw_valid || ar_valid) begin
          check_value("aw_ready", aw_ready, 0);
          check_value("ar_ready", ar_ready, 0);
        end
        @(negedge clk);
        check_value(is_wr ? "b_valid" : "r_valid", is_wr ? b_valid : r_valid, 1);
        check_value(is_wr ? "b" : "r", resp_payload(is_wr), snap);
      end
      if (is_wr) begin
        b_ready = 1'b1;
      end else begin
        r_ready = 1'b1;
      end
      @(posedge clk);
      @(negedge clk);
      b_ready = 1'b0;
      r_ready = 1'b0;
      // taken, so the valid drops
      check_value(is_wr ? "b_valid" : "r_valid", is_wr ? b_valid : r_valid, 0);
    end
  endtask

  initial begin
    string                       line;
    int                          fd;
    int                          n;
    int                          i;
    int                          lines_run;
    int                          wr_cyc;
    int                          rd_cyc;
    byte                         op;
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [`AXIL_DATA_WIDTH-1:0] wdata;
    logic [`AXIL_DATA_WIDTH-1:0] exp_rdata;
    logic [`AXIL_DATA_WIDTH-1:0] rdata_got;
    logic [`AXIL_DATA_WIDTH-1:0] wr_rdata;
    logic [`AXIL_STRB_WIDTH-1:0] strb;
    logic [1:0]                  exp_resp;
    logic [1:0]                  bresp_got;
    logic [1:0]                  rresp_got;

    void'($urandom(32'h03fd_19bd));
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    lines_run = 0;

    for (i = 0; i < wait_limit; i++) begin
      @(negedge clk);
      if (rst_n) begin
        break;
      end
    end
    if (i == wait_limit) begin
      report_hang("reset release");
    end else begin
      // idle outputs stay low while nothing is requested
      repeat (2) begin
        @(negedge clk);
        check_value("aw_ready", aw_ready, 0);
        check_value("w_ready", w_ready, 0);
        check_value("ar_ready", ar_ready, 0);
        check_value("b_valid", b_valid, 0);
        check_value("r_valid", r_valid, 0);
      end

      fd = $fopen("testbench/axil_sram_testdata.txt", "r");
      if (fd == 0) begin
        $display("cannot open the test data file");
        other_errs++;
      end else begin
        while (!hung && $fgets(line, fd) != 0) begin
          if (line.len() < 2 || line[0] == "#") begin
            continue;
          end
          n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, strb,
                      exp_resp, exp_rdata);
          if (n != 6) begin
            $display("malformed test data line: %s", line);
            other_errs++;
            continue;
          end
          lines_run++;
          case (op)
            "w": begin
              send_addr(1'b1, addr, wdata, strb, wr_cyc);
              take_resp(1'b1, bresp_got, wr_rdata);
              check_value("bresp", bresp_got, exp_resp);
            end
            "r": begin
              send_addr(1'b0, addr, wdata, strb, rd_cyc);
              take_resp(1'b0, rresp_got, rdata_got);
              check_value("rresp", rresp_got, exp_resp);
              check_value("rdata", rdata_got, exp_rdata);
            end
            "p": begin
              fork
                begin
                  send_addr(1'b1, addr, wdata, strb, wr_cyc);
                  take_resp(1'b1, bresp_got, wr_rdata);
                end
                begin
                  send_addr(1'b0, addr, wdata, strb, rd_cyc);
                  take_resp(1'b0, rresp_got, rdata_got);
                end
              join
              check_value("bresp", bresp_got, exp_resp);
              check_value("rresp", rresp_got, exp_resp);
              // read after the write sees the merged word
              if (wr_cyc < rd_cyc) begin
                exp_rdata = merge_bytes(exp_rdata, wdata, strb);
              end
              check_value("rdata", rdata_got, exp_rdata);
            end
            default: begin
              $display("unknown operation '%c' in the test data", op);
              other_errs++;
            end
          endcase
        end
        $fclose(fd);
        if (lines_run == 0) begin
          $display("the test data file holds no transactions");
          other_errs++;
        end
      end
    end
    finish_run();
  end

endmodule

// ==== list.f ====
+incdir+include
src/axil_pkg.sv
src/sram_pkg.sv
src/sram_array.sv
src/axil_sram_bridge.sv
src/axil_sram_top.sv
testbench/tb_clk_gen.sv
testbench/axil_sram_tb.sv

// ==== Bender.yml ====
package:
  name: axil_sram

sources:
  - include_dirs:
      - include
    files:
      - src/axil_pkg.sv
      - src/sram_pkg.sv
      - src/sram_array.sv
      - src/axil_sram_bridge.sv
      - src/axil_sram_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clk_gen.sv
      - testbench/axil_sram_tb.sv

// ==== testbench/axil_sram_testdata.txt ====
# op addr wdata strb resp rdata, all hex; op w write, r read, p write and read together
# resp 0 okay, 2 slverr; for p the rdata column is the word before the write
w 0000 a5c3 3 0 0000
r 0000 0000 0 0 a5c3
w 07fe 0ff0 3 0 0000
r 07fe 0000 0 0 0ff0
w 0010 1234 3 0 0000
w 0010 beef 1 0 0000
r 0010 0000 0 0 12ef
w 0010 7788 2 0 0000
r 0010 0000 0 0 77ef
w 0004 cafe 3 0 0000
w 0804 dead 3 2 0000
r 0804 0000 0 2 0000
r 0004 0000 0 0 cafe
w fffe 1111 3 2 0000
r fffe 0000 0 2 0000
w 0020 0101 3 0 0000
r 07fe 0000 0 0 0ff0
p 0020 5a5a 1 0 0101
w 0030 4242 3 0 0000
p 0030 0000 3 0 4242
r 0030 0000 0 0 0000
r 0020 0000 0 0 015a
